//--- hw/msx_glue_pkg.sv
// Shared register map, field widths, crop constants and video types for the MSX glue logic
package msx_glue_pkg;

   // ============================================================
   // APB register map
   // ============================================================
   localparam int unsigned apb_addr_w = 4;
   localparam int unsigned apb_data_w = 32;

   localparam logic [apb_addr_w-1:0] reg_ctrl_addr   = 4'h0;
   localparam logic [apb_addr_w-1:0] reg_video_addr  = 4'h4;
   // Read-only, writes flag pslverr
   localparam logic [apb_addr_w-1:0] reg_status_addr = 4'h8;

   // VIDEO register field layout
   localparam int unsigned video_w   = 10;
   localparam int unsigned vmode_lsb = 7;

   // ============================================================
   // Field widths
   // ============================================================
   localparam int unsigned hdmi_dim_w = 12;
   localparam int unsigned crop_w     = 10;
   localparam int unsigned ar_w       = 12;
   localparam int unsigned img_size_w = 32;

   // Aspect and crop constants
   localparam logic [ar_w-1:0]       ar_x_normal    = 12'd400;
   localparam logic [ar_w-1:0]       ar_x_wide      = 12'd340;
   localparam logic [ar_w-1:0]       ar_y_normal    = 12'd300;
   // 4:3 modes at 1920x1440 and 2048x1536
   localparam logic [hdmi_dim_w-1:0] wide_min_width = 12'd1440;

   // SD activity idle timeout, about 47 ms at 21.48 MHz
   localparam int unsigned sd_act_timeout_default = 1000000;

   // ============================================================
   // Video types
   // ============================================================
   typedef enum logic [1:0] {
      std_auto = 2'd0,
      std_pal  = 2'd1,
      std_ntsc = 2'd2
   } video_std_e;

   // Video-mode field, MSX1 uses one flag, MSX2 a 2-bit selector
   typedef union packed {
      struct packed {
         logic [1:0] unused;
         logic       ntsc;
      } msx1;
      struct packed {
         logic [1:0] mode;
         logic       unused;
      } msx2;
   } video_mode_u;

endpackage

//--- hw/msx_cfg_regs.sv
// APB config and status registers with video-mode decode and core reset combining
`timescale 1ns/100ps

module msx_cfg_regs (
   input  logic                                clk21m,
   input  logic                                reset,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [msx_glue_pkg::apb_addr_w-1:0] paddr,
   input  logic [msx_glue_pkg::apb_data_w-1:0] pwdata,
   input  logic                                sd_act,
   input  logic                                vsd_sel,
   output logic [msx_glue_pkg::apb_data_w-1:0] prdata,
   output logic                                pready,
   output logic                                pslverr,
   output logic                                core_reset,
   output msx_glue_pkg::video_std_e            video_std,
   output logic [1:0]                          aspect,
   output logic [1:0]                          scale,
   output logic [1:0]                          vga_sl,
   output logic                                vcrop_en,
   output logic                                scandoubler_req
);

   // CTRL fields, soft reset and detach are one-shot
   logic ctrl_soft;
   logic ctrl_detach;
   logic msx_type;
   // VIDEO register
   logic [msx_glue_pkg::video_w-1:0] video_q;

   logic access;
   logic wr_en;
   logic addr_ok;
   msx_glue_pkg::video_mode_u vmode;

   // ============================================================
   // APB decode
   // ============================================================
   // Zero wait states
   assign pready = 1'b1;
   assign access = psel & penable;
   assign wr_en  = access & pwrite;

   assign addr_ok = (paddr == msx_glue_pkg::reg_ctrl_addr)
                 || (paddr == msx_glue_pkg::reg_video_addr)
                 || (paddr == msx_glue_pkg::reg_status_addr);

   // Unmapped offset or write to STATUS
   assign pslverr = access
                 & (~addr_ok | (pwrite & (paddr == msx_glue_pkg::reg_status_addr)));

   // Read mux
   always_comb begin
      prdata = '0;
      case (paddr)
         msx_glue_pkg::reg_ctrl_addr:   prdata[2:0] = {msx_type, ctrl_detach, ctrl_soft};
         msx_glue_pkg::reg_video_addr:  prdata[msx_glue_pkg::video_w-1:0] = video_q;
         msx_glue_pkg::reg_status_addr: prdata[1:0] = {vsd_sel, sd_act};
         default:                       prdata = '0;
      endcase
   end

   // ============================================================
   // Register writes and core reset
   // ============================================================
   always_ff @(posedge clk21m) begin
      if (reset) begin
         ctrl_soft   <= 1'b0;
         ctrl_detach <= 1'b0;
         msx_type    <= 1'b0;
         video_q     <= '0;
         // Core held in reset with the board
         core_reset  <= 1'b1;
      end else begin
         // One-shot bits clear on the next edge
         ctrl_soft   <= 1'b0;
         ctrl_detach <= 1'b0;
         if (wr_en && (paddr == msx_glue_pkg::reg_ctrl_addr)) begin
            ctrl_soft   <= pwdata[0];
            ctrl_detach <= pwdata[1];
            msx_type    <= pwdata[2];
         end
         if (wr_en && (paddr == msx_glue_pkg::reg_video_addr)) begin
            video_q <= pwdata[msx_glue_pkg::video_w-1:0];
         end
         // Single-cycle pulse one edge after the request
         core_reset <= ctrl_soft | ctrl_detach;
      end
   end

   // ============================================================
   // Video settings
   // ============================================================
   assign aspect          = video_q[1:0];
   assign vga_sl          = video_q[3:2];
   assign scale           = video_q[5:4];
   assign vcrop_en        = video_q[6];
   // Any scanline setting needs the scandoubler
   assign scandoubler_req = |video_q[3:2];

   assign vmode = video_q[msx_glue_pkg::video_w-1:msx_glue_pkg::vmode_lsb];

   // MSX1 only knows PAL or NTSC, MSX2 adds auto
   always_comb begin
      if (!msx_type) begin
         video_std = vmode.msx1.ntsc ? msx_glue_pkg::std_ntsc : msx_glue_pkg::std_pal;
      end else begin
         case (vmode.msx2.mode)
            2'd1:    video_std = msx_glue_pkg::std_pal;
            2'd2:    video_std = msx_glue_pkg::std_ntsc;
            // Code 3 falls back to auto
            default: video_std = msx_glue_pkg::std_auto;
         endcase
      end
   end

endmodule

//--- hw/video_crop_select.sv
// HDMI vertical crop, wide flag and aspect-ratio selection from output size and settings
`timescale 1ns/100ps

module video_crop_select (
   input  logic                                clk21m,
   input  logic                                reset,
   input  logic [msx_glue_pkg::hdmi_dim_w-1:0] hdmi_width,
   input  logic [msx_glue_pkg::hdmi_dim_w-1:0] hdmi_height,
   input  logic                                forced_scandoubler,
   input  logic                                scandoubler_req,
   input  logic [1:0]                          aspect,
   input  logic                                vcrop_en,
   output logic [msx_glue_pkg::ar_w-1:0]       arx,
   output logic [msx_glue_pkg::ar_w-1:0]       ary,
   output logic [msx_glue_pkg::crop_w-1:0]     crop_size
);

   logic                                scandoubler;
   // Height times 1.5, one extra bit against overflow
   logic [msx_glue_pkg::hdmi_dim_w:0]   height_x15;
   logic                                is_wide_screen;
   logic                                is_big_43;
   logic [msx_glue_pkg::crop_w-1:0]     crop_next;
   logic                                wide_next;
   // Stage 1
   logic [msx_glue_pkg::crop_w-1:0]     crop_q;
   logic                                wide_q;

   assign scandoubler = forced_scandoubler | scandoubler_req;

   assign height_x15 = {1'b0, hdmi_height}
                     + {2'b00, hdmi_height[msx_glue_pkg::hdmi_dim_w-1:1]};

   assign is_wide_screen = ({1'b0, hdmi_width} >= height_x15) && !scandoubler;
   assign is_big_43      = (hdmi_width >= msx_glue_pkg::wide_min_width) && !scandoubler;

   // ============================================================
   // Crop lookup
   // ============================================================
   always_comb begin
      crop_next = '0;
      wide_next = 1'b0;
      if (is_wide_screen) begin
         case (hdmi_height)
            12'd480:  crop_next = 10'd240;
            12'd600: begin
               crop_next = 10'd200;
               wide_next = vcrop_en;
            end
            12'd720:  crop_next = 10'd240;
            // NTSC only shows 250 of these lines
            12'd768:  crop_next = 10'd256;
            12'd800: begin
               crop_next = 10'd200;
               wide_next = vcrop_en;
            end
            12'd1080: crop_next = 10'd216;
            12'd1200: crop_next = 10'd240;
            default:  crop_next = '0;
         endcase
      end else if (is_big_43) begin
         // 4:3 modes narrower than 1.5x height
         case (hdmi_height)
            12'd1440: crop_next = 10'd240;
            12'd1536: crop_next = 10'd256;
            default:  crop_next = '0;
         endcase
      end
   end

   // ============================================================
   // Two register stages
   // ============================================================
   always_ff @(posedge clk21m) begin
      if (reset) begin
         crop_q    <= '0;
         wide_q    <= 1'b0;
         // Values for VIDEO = 0
         arx       <= msx_glue_pkg::ar_x_normal;
         ary       <= msx_glue_pkg::ar_y_normal;
         crop_size <= '0;
      end else begin
         crop_q <= crop_next;
         wide_q <= wide_next;
         if (aspect == 2'd0) begin
            // Original ratio, narrower when cropping wide modes
            arx <= wide_q ? msx_glue_pkg::ar_x_wide : msx_glue_pkg::ar_x_normal;
            ary <= msx_glue_pkg::ar_y_normal;
         end else begin
            // Custom ARC index with ary zero
            arx <= {{(msx_glue_pkg::ar_w-2){1'b0}}, aspect - 2'd1};
            ary <= '0;
         end
         crop_size <= vcrop_en ? crop_q : '0;
      end
   end

endmodule

//--- hw/sd_route.sv
// SPI routing between physical SD card and virtual card image with bus activity detect
`timescale 1ns/100ps

module sd_route #(
   parameter int unsigned act_timeout = msx_glue_pkg::sd_act_timeout_default
) (
   input  logic                                clk21m,
   input  logic                                reset,
   input  logic                                img_mounted,
   input  logic [msx_glue_pkg::img_size_w-1:0] img_size,
   input  logic                                spi_ss,
   input  logic                                spi_clk,
   input  logic                                spi_mosi,
   input  logic                                sd_miso,
   input  logic                                vsd_miso,
   output logic                                sd_cs,
   output logic                                sd_sck,
   output logic                                sd_mosi,
   output logic                                spi_miso,
   output logic                                vsd_ss,
   output logic                                vsd_sel,
   output logic                                sd_act
);

   // Previous data line levels
   logic mosi_q;
   logic miso_q;
   logic activity;
   logic [$clog2(act_timeout + 1)-1:0] idle_cnt;

   // ============================================================
   // Card select
   // ============================================================
   // Nonzero image means virtual card
   always_ff @(posedge clk21m) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical card parked while the image is used
   assign sd_cs    = spi_ss | vsd_sel;
   assign sd_sck   = spi_clk & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;
   assign vsd_ss   = spi_ss | ~vsd_sel;
   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

   // ============================================================
   // Activity detect
   // ============================================================
   always_ff @(posedge clk21m) begin
      mosi_q <= spi_mosi;
      miso_q <= spi_miso;
   end

   assign activity = (mosi_q ^ spi_mosi) | (miso_q ^ spi_miso);

   always_ff @(posedge clk21m) begin
      if (reset) begin
         idle_cnt <= '0;
         sd_act   <= 1'b0;
      end else if (activity) begin
         idle_cnt <= '0;
         sd_act   <= 1'b1;
      end else if (sd_act) begin
         // Count idle cycles until timeout
         idle_cnt <= idle_cnt + 1'b1;
         if (32'(idle_cnt) == act_timeout - 1) begin
            sd_act <= 1'b0;
         end
      end
   end

endmodule

//--- hw/msx_glue.sv
// MSX glue top level joining the config registers, HDMI crop select and SD routing
`timescale 1ns/100ps

module msx_glue #(
   parameter int unsigned act_timeout = msx_glue_pkg::sd_act_timeout_default
) (
   input  logic                                  clk21m,
   input  logic                                  reset,
   // APB host port
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [msx_glue_pkg::apb_addr_w-1:0]   paddr,
   input  logic [msx_glue_pkg::apb_data_w-1:0]   pwdata,
   output logic [msx_glue_pkg::apb_data_w-1:0]   prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   // Core control
   output logic                                  core_reset,
   output msx_glue_pkg::video_std_e              video_std,
   // Video
   input  logic [msx_glue_pkg::hdmi_dim_w-1:0]   hdmi_width,
   input  logic [msx_glue_pkg::hdmi_dim_w-1:0]   hdmi_height,
   input  logic                                  forced_scandoubler,
   output logic [1:0]                            vga_sl,
   output logic [1:0]                            scale,
   output logic [msx_glue_pkg::ar_w-1:0]         arx,
   output logic [msx_glue_pkg::ar_w-1:0]         ary,
   output logic [msx_glue_pkg::crop_w-1:0]       crop_size,
   // SD card
   input  logic                                  img_mounted,
   input  logic [msx_glue_pkg::img_size_w-1:0]   img_size,
   input  logic                                  spi_ss,
   input  logic                                  spi_clk,
   input  logic                                  spi_mosi,
   input  logic                                  sd_miso,
   input  logic                                  vsd_miso,
   output logic                                  sd_cs,
   output logic                                  sd_sck,
   output logic                                  sd_mosi,
   output logic                                  spi_miso,
   output logic                                  vsd_ss
);

   // Video settings from registers to crop select
   logic [1:0] aspect;
   logic       vcrop_en;
   logic       scandoubler_req;
   // SD status back to registers
   logic       sd_act;
   logic       vsd_sel;

   // ============================================================
   // Config and status registers
   // ============================================================
   msx_cfg_regs cfg_regs_i (
      .clk21m          (clk21m),
      .reset           (reset),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .sd_act          (sd_act),
      .vsd_sel         (vsd_sel),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .core_reset      (core_reset),
      .video_std       (video_std),
      .aspect          (aspect),
      .scale           (scale),
      .vga_sl          (vga_sl),
      .vcrop_en        (vcrop_en),
      .scandoubler_req (scandoubler_req)
   );

   // ============================================================
   // HDMI crop and aspect
   // ============================================================
   video_crop_select crop_sel_i (
      .clk21m             (clk21m),
      .reset              (reset),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .scandoubler_req    (scandoubler_req),
      .aspect             (aspect),
      .vcrop_en           (vcrop_en),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size)
   );

   // ============================================================
   // SD card routing
   // ============================================================
   sd_route #(
      .act_timeout (act_timeout)
   ) sd_route_i (
      .clk21m      (clk21m),
      .reset       (reset),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_ss      (spi_ss),
      .spi_clk     (spi_clk),
      .spi_mosi    (spi_mosi),
      .sd_miso     (sd_miso),
      .vsd_miso    (vsd_miso),
      .sd_cs       (sd_cs),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .spi_miso    (spi_miso),
      .vsd_ss      (vsd_ss),
      .vsd_sel     (vsd_sel),
      .sd_act      (sd_act)
   );

endmodule

//--- tb/msx_glue_sva.sv
// Concurrent assertions on the MSX glue APB slave, core reset pulse and SD routing
`timescale 1ns/100ps

module msx_glue_sva (
   input logic                                clk21m,
   input logic                                reset,
   input logic                                psel,
   input logic                                penable,
   input logic                                pslverr,
   input logic                                core_reset,
   input logic                                img_mounted,
   input logic [msx_glue_pkg::img_size_w-1:0] img_size,
   input logic                                sd_cs,
   input logic                                vsd_sel
);

   // Count of failed assertions
   int fail_count = 0;

   // ============================================================
   // APB protocol
   // ============================================================
   // Error response only in an access phase that follows a setup phase
   pslverr_in_access: assert property (@(posedge clk21m) disable iff (reset)
      pslverr |-> (psel && penable && $past(psel && !penable)))
      else begin
         fail_count++;
         $error("pslverr high outside an APB access phase");
      end

   // ============================================================
   // Core reset and SD routing
   // ============================================================
   // Soft reset gives a single-cycle pulse
   core_reset_one_cycle: assert property (@(posedge clk21m) disable iff (reset)
      $rose(core_reset) |=> !core_reset)
      else begin
         fail_count++;
         $error("core_reset pulse longer than one cycle");
      end

   // Physical card parked from a nonzero mount until the next mount
   sd_cs_parked: assert property (@(posedge clk21m) disable iff (reset)
      ((img_mounted && (img_size != '0)) || (vsd_sel && !img_mounted)) |=> sd_cs)
      else begin
         fail_count++;
         $error("sd_cs low while the virtual card is selected");
      end

endmodule

// Watches the register block and SD router from the top level
bind msx_glue msx_glue_sva sva_i (
   .clk21m      (clk21m),
   .reset       (reset),
   .psel        (psel),
   .penable     (penable),
   .pslverr     (pslverr),
   .core_reset  (core_reset),
   .img_mounted (img_mounted),
   .img_size    (img_size),
   .sd_cs       (sd_cs),
   .vsd_sel     (vsd_sel)
);

//--- tb/msx_glue_tb.sv
// Table-driven testbench for the MSX glue registers, HDMI crop select and SD routing
`timescale 1ns/100ps

module msx_glue_tb;

   localparam int num_rows        = 16;
   localparam int watchdog_cycles = num_rows * 20 + 2000;

   // HDMI size, settings and expected crop and aspect
   typedef struct packed {
      logic [11:0] width;
      logic [11:0] height;
      logic        forced;
      logic [1:0]  sl;
      logic [1:0]  aspect;
      logic        vcrop;
      logic [9:0]  crop;
      logic [11:0] arx;
      logic [11:0] ary;
   } video_case_t;

   localparam video_case_t video_cases [0:num_rows-1] = '{
      '{12'd1920, 12'd1080, 1'b0, 2'd0, 2'd0, 1'b1, 10'd216, 12'd400, 12'd300},
      '{12'd1280, 12'd720,  1'b0, 2'd0, 2'd0, 1'b1, 10'd240, 12'd400, 12'd300},
      '{12'd1024, 12'd600,  1'b0, 2'd0, 2'd0, 1'b1, 10'd200, 12'd340, 12'd300},
      '{12'd1280, 12'd800,  1'b0, 2'd0, 2'd0, 1'b0, 10'd0,   12'd400, 12'd300},
      '{12'd1280, 12'd800,  1'b0, 2'd0, 2'd0, 1'b1, 10'd200, 12'd340, 12'd300},
      '{12'd1920, 12'd1440, 1'b0, 2'd0, 2'd0, 1'b1, 10'd240, 12'd400, 12'd300},
      '{12'd2048, 12'd1536, 1'b0, 2'd0, 2'd0, 1'b1, 10'd256, 12'd400, 12'd300},
      '{12'd1920, 12'd1080, 1'b1, 2'd0, 2'd0, 1'b1, 10'd0,   12'd400, 12'd300},
      '{12'd1920, 12'd1080, 1'b0, 2'd1, 2'd0, 1'b1, 10'd0,   12'd400, 12'd300},
      '{12'd1024, 12'd768,  1'b0, 2'd0, 2'd0, 1'b1, 10'd0,   12'd400, 12'd300},
      '{12'd1366, 12'd768,  1'b0, 2'd0, 2'd0, 1'b1, 10'd256, 12'd400, 12'd300},
      '{12'd1920, 12'd1080, 1'b0, 2'd0, 2'd2, 1'b1, 10'd216, 12'd1,   12'd0},
      '{12'd1024, 12'd600,  1'b0, 2'd0, 2'd3, 1'b1, 10'd200, 12'd2,   12'd0},
      '{12'd640,  12'd480,  1'b0, 2'd0, 2'd0, 1'b1, 10'd0,   12'd400, 12'd300},
      '{12'd800,  12'd480,  1'b0, 2'd0, 2'd0, 1'b1, 10'd240, 12'd400, 12'd300},
      '{12'd1920, 12'd1200, 1'b0, 2'd0, 2'd0, 1'b1, 10'd240, 12'd400, 12'd300}
   };

   // Expected standard per video-mode code, MSX1 then MSX2
   localparam msx_glue_pkg::video_std_e msx1_std [0:7] = '{
      msx_glue_pkg::std_pal, msx_glue_pkg::std_ntsc, msx_glue_pkg::std_pal,
      msx_glue_pkg::std_ntsc, msx_glue_pkg::std_pal, msx_glue_pkg::std_ntsc,
      msx_glue_pkg::std_pal, msx_glue_pkg::std_ntsc
   };
   localparam msx_glue_pkg::video_std_e msx2_std [0:7] = '{
      msx_glue_pkg::std_auto, msx_glue_pkg::std_auto, msx_glue_pkg::std_pal,
      msx_glue_pkg::std_pal, msx_glue_pkg::std_ntsc, msx_glue_pkg::std_ntsc,
      msx_glue_pkg::std_auto, msx_glue_pkg::std_auto
   };

   logic        clk21m;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        core_reset;
   msx_glue_pkg::video_std_e video_std;
   logic [11:0] hdmi_width;
   logic [11:0] hdmi_height;
   logic        forced_scandoubler;
   logic [1:0]  vga_sl;
   logic [1:0]  scale;
   logic [11:0] arx;
   logic [11:0] ary;
   logic [9:0]  crop_size;
   logic        img_mounted;
   logic [31:0] img_size;
   logic        spi_ss;
   logic        spi_clk;
   logic        spi_mosi;
   logic        sd_miso;
   logic        vsd_miso;
   logic        sd_cs;
   logic        sd_sck;
   logic        sd_mosi;
   logic        spi_miso;
   logic        vsd_ss;

   int          errors;
   int          seed;

   msx_glue #(
      .act_timeout (64)
   ) dut_i (
      .clk21m (clk21m), .reset (reset),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
      .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
      .core_reset (core_reset), .video_std (video_std),
      .hdmi_width (hdmi_width), .hdmi_height (hdmi_height),
      .forced_scandoubler (forced_scandoubler), .vga_sl (vga_sl), .scale (scale),
      .arx (arx), .ary (ary), .crop_size (crop_size),
      .img_mounted (img_mounted), .img_size (img_size), .spi_ss (spi_ss),
      .spi_clk (spi_clk), .spi_mosi (spi_mosi), .sd_miso (sd_miso),
      .vsd_miso (vsd_miso), .sd_cs (sd_cs), .sd_sck (sd_sck), .sd_mosi (sd_mosi),
      .spi_miso (spi_miso), .vsd_ss (vsd_ss)
   );

   // 25 MHz stand-in for the 21.48 MHz clock
   initial begin
      clk21m = 1'b0;
      forever #20 clk21m = ~clk21m;
   end

   // Watchdog
   initial begin
      repeat (watchdog_cycles) @(posedge clk21m);
      $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

   // ============================================================
   // Check and bus tasks
   // ============================================================
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      end
   endtask

   // Setup phase, access phase, then idle; sampled mid-cycle
   task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
      @(negedge clk21m);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk21m);
      penable = 1'b1;
      #10;
      rdata = prdata;
      err   = pslverr;
      // Zero wait states
      check_value("pready", pready, 1);
      @(negedge clk21m);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused_rdata;
      apb_xfer(1'b1, addr, data, unused_rdata, err);
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic err);
      apb_xfer(1'b0, addr, 32'h0, data, err);
   endtask

   // Mount pulse, one cycle
   task automatic mount_image(input logic [31:0] size);
      @(negedge clk21m);
      img_size    = size;
      img_mounted = 1'b1;
      @(negedge clk21m);
      img_mounted = 1'b0;
   endtask

   // ============================================================
   // Main sequence
   // ============================================================
   initial begin
      logic [31:0] rdata;
      logic [31:0] wdata;
      logic        err;
      int          wait_cnt;
      video_case_t vc;

      errors = 0;
      seed   = 42145;
      reset = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      hdmi_width = 12'd1920;
      hdmi_height = 12'd1080;
      forced_scandoubler = 1'b0;
      img_mounted = 1'b0;
      img_size = '0;
      spi_ss = 1'b1;
      spi_clk = 1'b0;
      spi_mosi = 1'b0;
      sd_miso = 1'b0;
      vsd_miso = 1'b1;

      repeat (8) @(negedge clk21m);
      check_value("core_reset", core_reset, 1);
      repeat (8) @(negedge clk21m);
      reset = 1'b0;

      // Reset values
      apb_read(msx_glue_pkg::reg_ctrl_addr, rdata, err);
      check_value("ctrl", rdata, 0);
      apb_read(msx_glue_pkg::reg_video_addr, rdata, err);
      check_value("video", rdata, 0);
      apb_read(msx_glue_pkg::reg_status_addr, rdata, err);
      check_value("status", rdata, 0);
      check_value("sd_act", sd_act_now(), 0);

      // VIDEO readback masked to 10 bits
      for (int i = 0; i < 8; i++) begin
         wdata = $random(seed);
         apb_write(msx_glue_pkg::reg_video_addr, wdata, err);
         check_value("pslverr", err, 0);
         apb_read(msx_glue_pkg::reg_video_addr, rdata, err);
         check_value("video", rdata, wdata & 32'h3ff);
         // Scanline and scale fields straight to the video outputs
         check_value("vga_sl", vga_sl, wdata[3:2]);
         check_value("scale", scale, wdata[5:4]);
      end
      apb_read(4'hc, rdata, err);
      check_value("pslverr", err, 1);
      apb_write(msx_glue_pkg::reg_status_addr, 32'h3, err);
      check_value("pslverr", err, 1);

      // Crop and aspect table
      for (int r = 0; r < num_rows; r++) begin
         vc = video_cases[r];
         @(negedge clk21m);
         hdmi_width         = vc.width;
         hdmi_height        = vc.height;
         forced_scandoubler = vc.forced;
         wdata = {25'd0, vc.vcrop, 2'd0, vc.sl, vc.aspect};
         apb_write(msx_glue_pkg::reg_video_addr, wdata, err);
         repeat (4) @(negedge clk21m);
         check_value($sformatf("crop_size[%0d]", r), crop_size, vc.crop);
         check_value($sformatf("arx[%0d]", r), arx, vc.arx);
         check_value($sformatf("ary[%0d]", r), ary, vc.ary);
      end
      forced_scandoubler = 1'b0;

      // Video-mode decode for MSX1 then MSX2
      apb_write(msx_glue_pkg::reg_ctrl_addr, 32'h0, err);
      for (int m = 0; m < 8; m++) begin
         apb_write(msx_glue_pkg::reg_video_addr, m << msx_glue_pkg::vmode_lsb, err);
         check_value("video_std msx1", video_std, msx1_std[m]);
      end
      apb_write(msx_glue_pkg::reg_ctrl_addr, 32'h4, err);
      for (int m = 0; m < 8; m++) begin
         apb_write(msx_glue_pkg::reg_video_addr, m << msx_glue_pkg::vmode_lsb, err);
         check_value("video_std msx2", video_std, msx2_std[m]);
      end

      // Soft reset pulse
      apb_write(msx_glue_pkg::reg_ctrl_addr, 32'h1, err);
      check_value("core_reset", core_reset, 0);
      @(negedge clk21m);
      check_value("core_reset", core_reset, 1);
      @(negedge clk21m);
      check_value("core_reset", core_reset, 0);
      apb_read(msx_glue_pkg::reg_ctrl_addr, rdata, err);
      check_value("ctrl", rdata, 0);

      // SPI activity rise and idle timeout
      @(negedge clk21m);
      spi_mosi = 1'b1;
      wait_cnt = 0;
      while (!sd_act_now() && wait_cnt < 2) begin
         @(negedge clk21m);
         wait_cnt++;
      end
      if (!sd_act_now()) begin
         errors++;
         $display("sd_act did not rise within 2 cycles after a MOSI toggle");
      end
      repeat (32) @(negedge clk21m);
      check_value("sd_act", sd_act_now(), 1);
      repeat (34) @(negedge clk21m);
      check_value("sd_act", sd_act_now(), 0);

      // Virtual card selected
      mount_image(32'h0010_0000);
      spi_ss  = 1'b0;
      spi_clk = 1'b1;
      @(negedge clk21m);
      check_value("spi_miso", spi_miso, vsd_miso);
      check_value("sd_cs", sd_cs, 1);
      check_value("sd_sck", sd_sck, 0);
      check_value("sd_mosi", sd_mosi, 0);
      check_value("vsd_ss", vsd_ss, 0);
      apb_read(msx_glue_pkg::reg_status_addr, rdata, err);
      check_value("status vsd_sel", rdata & 32'h2, 32'h2);

      // Physical card back on the bus
      mount_image(32'h0);
      @(negedge clk21m);
      check_value("spi_miso", spi_miso, sd_miso);
      check_value("sd_cs", sd_cs, spi_ss);
      check_value("sd_sck", sd_sck, spi_clk);
      check_value("sd_mosi", sd_mosi, spi_mosi);
      check_value("vsd_ss", vsd_ss, 1);
      apb_read(msx_glue_pkg::reg_status_addr, rdata, err);
      check_value("status vsd_sel", rdata & 32'h2, 32'h0);

      // Bound assertion failures count as errors too
      errors += dut_i.sva_i.fail_count;

      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // SD activity flag as seen in the router
   function automatic logic sd_act_now();
      return dut_i.sd_act;
   endfunction

endmodule

//--- msx_glue.f
hw/msx_glue_pkg.sv
hw/msx_cfg_regs.sv
hw/video_crop_select.sv
hw/sd_route.sv
hw/msx_glue.sv
tb/msx_glue_sva.sv
tb/msx_glue_tb.sv
